//--- design/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_INDEX_W = 4;
    localparam int ISSUE_W = 2;

    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;
    localparam int PFN_W = 20;
    localparam int OFFSET_W = 12;

    // reset entries live in kseg0, never consulted by lookups
    localparam logic [VPN2_W-1:0] RESET_VPN2_BASE = 19'h4_0000;
    localparam logic [2:0] CACHE_CACHEABLE = 3'd3;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [TLB_INDEX_W-1:0] tlb_index_t;

    // one page pair
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              G;
        logic [PFN_W-1:0]  pfn0;
        logic [2:0]        C0;
        logic              D0;
        logic              V0;
        logic [PFN_W-1:0]  pfn1;
        logic [2:0]        C1;
        logic              D1;
        logic              V1;
    } tlb_entry_t;

    typedef struct packed {
        logic       found;
        tlb_index_t index;
        paddr_t     paddr;
        logic [2:0] C;
        logic       D;
        logic       V;
    } tlb_search_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [3:0]  strobe;
        logic [31:0] data;
    } dbus_req_t;

    typedef struct packed {
        logic refill;
        logic invalid;
        logic modified;
    } tlb_exc_t;

    typedef struct packed {
        tlb_exc_t [ISSUE_W-1:0] i_tlb_exc;
        tlb_exc_t [ISSUE_W-1:0] d_tlb_exc;
    } mmu_exc_t;

endpackage

`default_nettype wire

//--- design/cp0_pkg.sv
`default_nettype none

package cp0_pkg;
    import mmu_pkg::*;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [4:0]        zero;
        logic [ASID_W-1:0] asid;
    } entry_hi_t;

    typedef struct packed {
        logic [5:0]       zero;
        logic [PFN_W-1:0] pfn;
        logic [2:0]       C;
        logic             D;
        logic             V;
        logic             G;
    } entry_lo_t;

    // P set when TLBP misses
    typedef struct packed {
        logic                    P;
        logic [30-TLB_INDEX_W:0] zero;
        logic [TLB_INDEX_W-1:0]  index;
    } index_t;

    typedef enum logic [1:0] {
        ENTRY_HI  = 2'd0,
        ENTRY_LO0 = 2'd1,
        ENTRY_LO1 = 2'd2,
        INDEX     = 2'd3
    } cp0_sel_e;

    typedef enum logic [2:0] {
        TLB_NONE = 3'd0,
        TLB_R    = 3'd1,
        TLB_WI   = 3'd2,
        TLB_WR   = 3'd3,
        TLB_P    = 3'd4
    } tlb_op_e;

endpackage

`default_nettype wire

//--- design/tlb_search.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_search
    import mmu_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 i_arst_n,
    input  wire logic [VPN2_W-1:0]              i_vpn2,
    input  wire                                 i_odd,
    input  wire logic [OFFSET_W-1:0]            i_offset,
    input  wire logic [ASID_W-1:0]              i_asid,
    input  wire tlb_entry_t [TLB_ENTRIES-1:0]   i_entries,
    output tlb_search_t                         o_result
);

    logic [TLB_ENTRIES-1:0] match;
    tlb_index_t             hit_index;
    tlb_entry_t             hit;

    always_comb begin
        for (int e = 0; e < TLB_ENTRIES; e++) begin
            match[e] = (i_entries[e].vpn2 == i_vpn2) &&
                       (i_entries[e].G || (i_entries[e].asid == i_asid));
        end
    end

    // or-encoder, valid only while match is one-hot
    always_comb begin
        hit_index = '0;
        for (int e = 0; e < TLB_ENTRIES; e++) begin
            if (match[e]) begin
                hit_index = hit_index | tlb_index_t'(e);
            end
        end
    end

    assign hit = i_entries[hit_index];

    always_comb begin
        o_result.found = |match;
        o_result.index = hit_index;
        if (i_odd) begin
            o_result.paddr = {hit.pfn1, i_offset};
            o_result.C     = hit.C1;
            o_result.D     = hit.D1;
            o_result.V     = hit.V1;
        end else begin
            o_result.paddr = {hit.pfn0, i_offset};
            o_result.C     = hit.C0;
            o_result.D     = hit.D0;
            o_result.V     = hit.V0;
        end
    end

    a_single_match: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(match));

endmodule

`default_nettype wire

//--- design/tlb.sv
`timescale 1ns/1ns
`default_nettype none

module tlb
    import mmu_pkg::*;
(
    input  wire                             clk,
    input  wire                             i_arst_n,
    input  wire logic [ASID_W-1:0]          i_asid,
    input  wire vaddr_t [ISSUE_W-1:0]       i_i_vaddr,
    input  wire vaddr_t [ISSUE_W-1:0]       i_d_vaddr,
    input  wire cp0_pkg::entry_hi_t         i_probe_hi,
    input  wire tlb_index_t                 i_r_index,
    input  wire                             i_we,
    input  wire tlb_index_t                 i_w_index,
    input  wire tlb_entry_t                 i_w_entry,
    output tlb_search_t [ISSUE_W-1:0]       o_i_result,
    output tlb_search_t [ISSUE_W-1:0]       o_d_result,
    output tlb_search_t                     o_probe_result,
    output tlb_entry_t                      o_r_entry
);

    tlb_entry_t [TLB_ENTRIES-1:0] entries;

    // distinct kseg0 page, nothing valid
    function automatic tlb_entry_t reset_entry(input tlb_index_t idx);
        tlb_entry_t e;
        e      = '0;
        e.vpn2 = RESET_VPN2_BASE | VPN2_W'(idx);
        return e;
    endfunction

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int e = 0; e < TLB_ENTRIES; e++) begin
                entries[e] <= reset_entry(tlb_index_t'(e));
            end
        end else if (i_we) begin
            entries[i_w_index] <= i_w_entry;
        end
    end

    assign o_r_entry = entries[i_r_index];

    for (genvar i = 0; i < ISSUE_W; i++) begin : g_slot
        tlb_search i_search_i (
            .clk,
            .i_arst_n,
            .i_vpn2    (i_i_vaddr[i][31:13]),
            .i_odd     (i_i_vaddr[i][12]),
            .i_offset  (i_i_vaddr[i][11:0]),
            .i_asid,
            .i_entries (entries),
            .o_result  (o_i_result[i])
        );

        tlb_search d_search_i (
            .clk,
            .i_arst_n,
            .i_vpn2    (i_d_vaddr[i][31:13]),
            .i_odd     (i_d_vaddr[i][12]),
            .i_offset  (i_d_vaddr[i][11:0]),
            .i_asid,
            .i_entries (entries),
            .o_result  (o_d_result[i])
        );
    end

    // TLBP probe, page half does not matter
    tlb_search probe_search_i (
        .clk,
        .i_arst_n,
        .i_vpn2    (i_probe_hi.vpn2),
        .i_odd     (1'b0),
        .i_offset  ('0),
        .i_asid    (i_probe_hi.asid),
        .i_entries (entries),
        .o_result  (o_probe_result)
    );

endmodule

`default_nettype wire

//--- design/mmu.sv
`timescale 1ns/1ns
`default_nettype none

module mmu
    import mmu_pkg::*;
    import cp0_pkg::*;
(
    input  wire                         clk,
    input  wire                         i_arst_n,
    input  wire logic [2:0]             i_config_k0,
    input  wire ibus_req_t [ISSUE_W-1:0] i_ireq,
    input  wire dbus_req_t [ISSUE_W-1:0] i_dreq,
    input  wire entry_hi_t              i_entry_hi,
    input  wire entry_lo_t              i_entry_lo0,
    input  wire entry_lo_t              i_entry_lo1,
    input  wire index_t                 i_index,
    input  wire tlb_index_t             i_random,
    input  wire                         i_tlb_we,
    input  wire                         i_tlb_wr,
    output ibus_req_t [ISSUE_W-1:0]     o_ireq,
    output dbus_req_t [ISSUE_W-1:0]     o_dreq,
    output logic [ISSUE_W-1:0]          o_d_uncache,
    output mmu_exc_t                    o_exc,
    output entry_hi_t                   o_r_hi,
    output entry_lo_t                   o_r_lo0,
    output entry_lo_t                   o_r_lo1,
    output index_t                      o_probe
);

    tlb_search_t [ISSUE_W-1:0] i_result;
    tlb_search_t [ISSUE_W-1:0] d_result;
    tlb_search_t               probe_result;
    tlb_entry_t                r_entry;
    tlb_entry_t                w_entry;
    tlb_index_t                w_index;
    logic [ISSUE_W-1:0]        i_mapped;
    logic [ISSUE_W-1:0]        d_mapped;
    tlb_exc_t [ISSUE_W-1:0]    i_exc;
    tlb_exc_t [ISSUE_W-1:0]    d_exc;

    // kuseg and kseg2/3 go through the TLB
    function automatic logic is_mapped(input vaddr_t va);
        return !va[31] || (va[31:30] == 2'b11);
    endfunction

    function automatic logic unmapped_uncached(input vaddr_t va, input logic [2:0] k0);
        return (va[31:29] == 3'b101) || ((va[31:29] == 3'b100) && (k0 != CACHE_CACHEABLE));
    endfunction

    function automatic tlb_entry_t pack_entry(input entry_hi_t hi, input entry_lo_t lo0,
                                              input entry_lo_t lo1);
        return '{vpn2: hi.vpn2, asid: hi.asid, G: lo0.G & lo1.G,
                 pfn0: lo0.pfn, C0: lo0.C, D0: lo0.D, V0: lo0.V,
                 pfn1: lo1.pfn, C1: lo1.C, D1: lo1.D, V1: lo1.V};
    endfunction

    assign w_entry = pack_entry(i_entry_hi, i_entry_lo0, i_entry_lo1);
    assign w_index = i_tlb_wr ? i_random : i_index.index;

    // TLBR result, G copied into both halves
    assign o_r_hi  = '{vpn2: r_entry.vpn2, zero: '0, asid: r_entry.asid};
    assign o_r_lo0 = '{zero: '0, pfn: r_entry.pfn0, C: r_entry.C0, D: r_entry.D0,
                       V: r_entry.V0, G: r_entry.G};
    assign o_r_lo1 = '{zero: '0, pfn: r_entry.pfn1, C: r_entry.C1, D: r_entry.D1,
                       V: r_entry.V1, G: r_entry.G};
    assign o_probe = '{P: !probe_result.found, zero: '0, index: probe_result.index};

    tlb tlb_i (
        .clk,
        .i_arst_n,
        .i_asid         (i_entry_hi.asid),
        .i_i_vaddr      ({i_ireq[1].addr, i_ireq[0].addr}),
        .i_d_vaddr      ({i_dreq[1].addr, i_dreq[0].addr}),
        .i_probe_hi     (i_entry_hi),
        .i_r_index      (i_index.index),
        .i_we           (i_tlb_we),
        .i_w_index      (w_index),
        .i_w_entry      (w_entry),
        .o_i_result     (i_result),
        .o_d_result     (d_result),
        .o_probe_result (probe_result),
        .o_r_entry      (r_entry)
    );

    for (genvar i = 0; i < ISSUE_W; i++) begin : g_slot
        assign i_mapped[i] = is_mapped(i_ireq[i].addr);
        assign d_mapped[i] = is_mapped(i_dreq[i].addr);

        assign i_exc[i].refill   = i_ireq[i].valid && i_mapped[i] && !i_result[i].found;
        assign i_exc[i].invalid  = i_ireq[i].valid && i_mapped[i] && i_result[i].found &&
                                   !i_result[i].V;
        assign i_exc[i].modified = 1'b0;

        assign d_exc[i].refill   = i_dreq[i].valid && d_mapped[i] && !d_result[i].found;
        assign d_exc[i].invalid  = i_dreq[i].valid && d_mapped[i] && d_result[i].found &&
                                   !d_result[i].V;
        // store to a clean page
        assign d_exc[i].modified = i_dreq[i].valid && d_mapped[i] && d_result[i].found &&
                                   d_result[i].V && !d_result[i].D && (|i_dreq[i].strobe);

        assign o_d_uncache[i] = d_mapped[i] ? (d_result[i].C != CACHE_CACHEABLE)
                                            : unmapped_uncached(i_dreq[i].addr, i_config_k0);

        always_comb begin
            o_ireq[i]       = i_ireq[i];
            o_ireq[i].addr  = i_mapped[i] ? i_result[i].paddr : {3'b000, i_ireq[i].addr[28:0]};
            o_ireq[i].valid = i_ireq[i].valid && !(|i_exc[i]);
        end

        always_comb begin
            o_dreq[i]       = i_dreq[i];
            o_dreq[i].addr  = d_mapped[i] ? d_result[i].paddr : {3'b000, i_dreq[i].addr[28:0]};
            o_dreq[i].valid = i_dreq[i].valid && !(|d_exc[i]);
        end
    end

    assign o_exc.i_tlb_exc = i_exc;
    assign o_exc.d_tlb_exc = d_exc;

endmodule

`default_nettype wire

//--- design/cp0_tlb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_tlb_regs
    import mmu_pkg::*;
    import cp0_pkg::*;
(
    input  wire                 clk,
    input  wire                 i_arst_n,
    input  wire                 i_cp0_we,
    input  wire cp0_sel_e       i_cp0_sel,
    input  wire logic [31:0]    i_cp0_wdata,
    input  wire tlb_op_e        i_tlb_op,
    input  wire entry_hi_t      i_r_hi,
    input  wire entry_lo_t      i_r_lo0,
    input  wire entry_lo_t      i_r_lo1,
    input  wire index_t         i_probe,
    output entry_hi_t           o_entry_hi,
    output entry_lo_t           o_entry_lo0,
    output entry_lo_t           o_entry_lo1,
    output index_t              o_index,
    output tlb_index_t          o_random,
    output logic                o_tlb_we,
    output logic                o_tlb_wr
);

    // TLB write happens at the edge ending the strobe cycle
    assign o_tlb_we = (i_tlb_op == TLB_WI) || (i_tlb_op == TLB_WR);
    assign o_tlb_wr = (i_tlb_op == TLB_WR);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_entry_hi  <= '0;
            o_entry_lo0 <= '0;
            o_entry_lo1 <= '0;
            o_index     <= '0;
        end else if (i_cp0_we) begin
            case (i_cp0_sel)
                ENTRY_HI: begin
                    o_entry_hi      <= entry_hi_t'(i_cp0_wdata);
                    o_entry_hi.zero <= '0;
                end
                ENTRY_LO0: begin
                    o_entry_lo0      <= entry_lo_t'(i_cp0_wdata);
                    o_entry_lo0.zero <= '0;
                end
                ENTRY_LO1: begin
                    o_entry_lo1      <= entry_lo_t'(i_cp0_wdata);
                    o_entry_lo1.zero <= '0;
                end
                default: begin
                    o_index      <= index_t'(i_cp0_wdata);
                    o_index.zero <= '0;
                end
            endcase
        end else begin
            case (i_tlb_op)
                TLB_R: begin
                    o_entry_hi  <= i_r_hi;
                    o_entry_lo0 <= i_r_lo0;
                    o_entry_lo1 <= i_r_lo1;
                end
                TLB_P:   o_index <= i_probe;
                default: ;
            endcase
        end
    end

    // free running down counter that wraps over the whole TLB
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_random <= tlb_index_t'(TLB_ENTRIES - 1);
        end else if (o_random == '0) begin
            o_random <= tlb_index_t'(TLB_ENTRIES - 1);
        end else begin
            o_random <= o_random - 1'b1;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_cp0_we && (i_tlb_op != TLB_NONE)));

endmodule

`default_nettype wire

//--- design/mmu_top.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_top
    import mmu_pkg::*;
    import cp0_pkg::*;
(
    input  wire                          clk,
    input  wire                          i_arst_n,
    input  wire logic [2:0]              i_config_k0,
    input  wire ibus_req_t [ISSUE_W-1:0] i_ireq,
    input  wire dbus_req_t [ISSUE_W-1:0] i_dreq,
    input  wire                          i_cp0_we,
    input  wire cp0_sel_e                i_cp0_sel,
    input  wire logic [31:0]             i_cp0_wdata,
    input  wire tlb_op_e                 i_tlb_op,
    output ibus_req_t [ISSUE_W-1:0]      o_ireq,
    output dbus_req_t [ISSUE_W-1:0]      o_dreq,
    output logic [ISSUE_W-1:0]           o_d_uncache,
    output mmu_exc_t                     o_exc,
    output entry_hi_t                    o_entry_hi,
    output entry_lo_t                    o_entry_lo0,
    output entry_lo_t                    o_entry_lo1,
    output index_t                       o_index,
    output tlb_index_t                   o_random
);

    logic      tlb_we;
    logic      tlb_wr;
    entry_hi_t r_hi;
    entry_lo_t r_lo0;
    entry_lo_t r_lo1;
    index_t    probe;

    cp0_tlb_regs cp0_tlb_regs_i (
        .clk,
        .i_arst_n,
        .i_cp0_we,
        .i_cp0_sel,
        .i_cp0_wdata,
        .i_tlb_op,
        .i_r_hi      (r_hi),
        .i_r_lo0     (r_lo0),
        .i_r_lo1     (r_lo1),
        .i_probe     (probe),
        .o_entry_hi,
        .o_entry_lo0,
        .o_entry_lo1,
        .o_index,
        .o_random,
        .o_tlb_we    (tlb_we),
        .o_tlb_wr    (tlb_wr)
    );

    mmu mmu_i (
        .clk,
        .i_arst_n,
        .i_config_k0,
        .i_ireq,
        .i_dreq,
        .i_entry_hi  (o_entry_hi),
        .i_entry_lo0 (o_entry_lo0),
        .i_entry_lo1 (o_entry_lo1),
        .i_index     (o_index),
        .i_random    (o_random),
        .i_tlb_we    (tlb_we),
        .i_tlb_wr    (tlb_wr),
        .o_ireq,
        .o_dreq,
        .o_d_uncache,
        .o_exc,
        .o_r_hi      (r_hi),
        .o_r_lo0     (r_lo0),
        .o_r_lo1     (r_lo1),
        .o_probe     (probe)
    );

endmodule

`default_nettype wire

//--- test/mmu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_tb
    import mmu_pkg::*;
    import cp0_pkg::*;
();

    logic                    clk;
    logic                    i_arst_n;
    logic [2:0]              i_config_k0;
    ibus_req_t [ISSUE_W-1:0] i_ireq;
    dbus_req_t [ISSUE_W-1:0] i_dreq;
    logic                    i_cp0_we;
    cp0_sel_e                i_cp0_sel;
    logic [31:0]             i_cp0_wdata;
    tlb_op_e                 i_tlb_op;
    ibus_req_t [ISSUE_W-1:0] o_ireq;
    dbus_req_t [ISSUE_W-1:0] o_dreq;
    logic [ISSUE_W-1:0]      o_d_uncache;
    mmu_exc_t                o_exc;
    entry_hi_t               o_entry_hi;
    entry_lo_t               o_entry_lo0;
    entry_lo_t               o_entry_lo1;
    index_t                  o_index;
    tlb_index_t              o_random;

    int         errors = 0;
    int         cycles = 0;
    int         cycle_limit = 20;
    int         edges_since_reset;
    tlb_index_t random_model;
    tlb_index_t last_wr_index = '0;
    string      lines[$];

    mmu_top dut_i (
        .clk,
        .i_arst_n,
        .i_config_k0,
        .i_ireq,
        .i_dreq,
        .i_cp0_we,
        .i_cp0_sel,
        .i_cp0_wdata,
        .i_tlb_op,
        .o_ireq,
        .o_dreq,
        .o_d_uncache,
        .o_exc,
        .o_entry_hi,
        .o_entry_lo0,
        .o_entry_lo1,
        .o_index,
        .o_random
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // clock edges since reset release
    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            edges_since_reset <= 0;
        end else begin
            edges_since_reset <= edges_since_reset + 1;
        end
    end

    // Random starts at the top entry and steps down once per edge
    assign random_model = tlb_index_t'(TLB_ENTRIES - 1 - (edges_since_reset % TLB_ENTRIES));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("%0d errors before the timeout", errors);
            $display("sim failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic reject_line(input string line);
        errors++;
        $display("malformed pattern line: %s", line);
    endtask

    task automatic read_patterns();
        int    fd;
        string line;
        string tag;
        fd = $fopen("test/mmu_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open test/mmu_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    // skip blank and comment lines
                    if ($sscanf(line, "%s", tag) == 1 && tag.substr(0, 0) != "#") begin
                        lines.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_line(input string line);
        string       tag;
        int          n;
        logic [31:0] k0, iv, ia0, ia1, dv, da0, da1, ds;
        logic [31:0] ep_i0, ep_i1, ep_d0, ep_d1, eiv, edv, eun, eexc;
        logic [31:0] exp_idx;
        logic [31:0] exp_addr;
        @(negedge clk);
        if (o_random !== random_model) begin
            report_mismatch("o_random", 32'(random_model), 32'(o_random));
        end
        i_cp0_we = 1'b0;
        i_tlb_op = TLB_NONE;
        i_ireq   = '0;
        i_dreq   = '0;
        n = $sscanf(line, "%s", tag);
        if (tag == "W") begin
            n = $sscanf(line, "%s %h %h", tag, k0, ia0);
            if (n != 3) begin
                reject_line(line);
            end else begin
                i_cp0_we    = 1'b1;
                i_cp0_sel   = cp0_sel_e'(k0[1:0]);
                i_cp0_wdata = ia0;
            end
        end else if (tag == "T") begin
            n = $sscanf(line, "%s %h", tag, k0);
            if (n != 2) begin
                reject_line(line);
            end else begin
                i_tlb_op = tlb_op_e'(k0[2:0]);
                if (i_tlb_op == TLB_WR) begin
                    last_wr_index = random_model;
                end
            end
        end else if (tag == "R") begin
            n = $sscanf(line, "%s %h %h %h %h %h", tag, ia0, ia1, da0, da1, ds);
            if (n != 6) begin
                reject_line(line);
            end else begin
                exp_idx = ds[0] ? {28'h0, last_wr_index} : da1;
                if (o_entry_hi !== ia0) begin
                    report_mismatch("o_entry_hi", ia0, o_entry_hi);
                end
                if (o_entry_lo0 !== ia1) begin
                    report_mismatch("o_entry_lo0", ia1, o_entry_lo0);
                end
                if (o_entry_lo1 !== da0) begin
                    report_mismatch("o_entry_lo1", da0, o_entry_lo1);
                end
                if (o_index !== exp_idx) begin
                    report_mismatch("o_index", exp_idx, o_index);
                end
            end
        end else if (tag == "X") begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", tag, k0,
                        iv, ia0, ia1, dv, da0, da1, ds, ep_i0, ep_i1, ep_d0, ep_d1, eiv, edv,
                        eun, eexc);
            if (n != 17) begin
                reject_line(line);
            end else begin
                i_config_k0 = k0[2:0];
                for (int s = 0; s < ISSUE_W; s++) begin
                    i_ireq[s].valid  = iv[s];
                    i_ireq[s].addr   = (s == 0) ? ia0 : ia1;
                    i_dreq[s].valid  = dv[s];
                    i_dreq[s].addr   = (s == 0) ? da0 : da1;
                    i_dreq[s].strobe = ds[4*s +: 4];
                    i_dreq[s].data   = 32'h5a5a_5a00 + 32'(s);
                end
                // sample just before the next rising edge
                #40;
                for (int s = 0; s < ISSUE_W; s++) begin
                    if (o_ireq[s].valid !== eiv[s]) begin
                        report_mismatch($sformatf("o_ireq[%0d].valid", s), 32'(eiv[s]),
                                        32'(o_ireq[s].valid));
                    end
                    exp_addr = (s == 0) ? ep_i0 : ep_i1;
                    if (eiv[s] && o_ireq[s].addr !== exp_addr) begin
                        report_mismatch($sformatf("o_ireq[%0d].addr", s), exp_addr,
                                        o_ireq[s].addr);
                    end
                    if (o_dreq[s].valid !== edv[s]) begin
                        report_mismatch($sformatf("o_dreq[%0d].valid", s), 32'(edv[s]),
                                        32'(o_dreq[s].valid));
                    end
                    exp_addr = (s == 0) ? ep_d0 : ep_d1;
                    if (edv[s] && o_dreq[s].addr !== exp_addr) begin
                        report_mismatch($sformatf("o_dreq[%0d].addr", s), exp_addr,
                                        o_dreq[s].addr);
                    end
                    if (edv[s] && o_d_uncache[s] !== eun[s]) begin
                        report_mismatch($sformatf("o_d_uncache[%0d]", s), 32'(eun[s]),
                                        32'(o_d_uncache[s]));
                    end
                    if (edv[s] && o_dreq[s].strobe !== ds[4*s +: 4]) begin
                        report_mismatch($sformatf("o_dreq[%0d].strobe", s),
                                        32'(ds[4*s +: 4]), 32'(o_dreq[s].strobe));
                    end
                    if (edv[s] && o_dreq[s].data !== i_dreq[s].data) begin
                        report_mismatch($sformatf("o_dreq[%0d].data", s), i_dreq[s].data,
                                        o_dreq[s].data);
                    end
                end
                if (o_exc !== eexc[11:0]) begin
                    report_mismatch("o_exc", eexc, 32'(o_exc));
                end
            end
        end else begin
            errors++;
            $display("unknown operation in pattern line: %s", line);
        end
    endtask

    initial begin
        i_arst_n    = 1'b0;
        i_config_k0 = 3'd3;
        i_ireq      = '0;
        i_dreq      = '0;
        i_cp0_we    = 1'b0;
        i_cp0_sel   = ENTRY_HI;
        i_cp0_wdata = '0;
        i_tlb_op    = TLB_NONE;
        read_patterns();
        cycle_limit = 4 * lines.size() + 20;
        if (lines.size() == 0) begin
            errors++;
            $display("no pattern lines were read");
        end
        repeat (4) @(negedge clk);
        i_arst_n = 1'b1;
        foreach (lines[n]) begin
            run_line(lines[n]);
        end
        @(negedge clk);
        i_cp0_we = 1'b0;
        i_tlb_op = TLB_NONE;
        $display("%0d errors over %0d pattern lines", errors, lines.size());
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/mmu_pkg.sv
design/cp0_pkg.sv
design/tlb_search.sv
design/tlb.sv
design/mmu.sv
design/cp0_tlb_regs.sv
design/mmu_top.sv
test/mmu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the MMU testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module mmu_tb -o mmu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/mmu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "no pass message found in sim.log"
    exit 1
fi
exit 0

//--- test/mmu_patterns.txt
# W sel data | T op (1 TLBR, 2 TLBWI, 3 TLBWR, 4 TLBP) | R hi lo0 lo1 index use_tlbwr_index
# X k0 ivalid ia0 ia1 dvalid da0 da1 strb | ipa0 ipa1 dpa0 dpa1 ivalid dvalid uncache exc
X 3 0 00400000 c0001000 0 00000000 10000000 00 00000000 00000000 00000000 00000000 0 0 0 000
X 3 3 80001000 a0002004 3 80003008 a0004000 00 00001000 00002004 00003008 00004000 3 3 2 000
X 2 3 80001000 a0002004 3 80003008 a0004000 ff 00001000 00002004 00003008 00004000 3 3 3 000
X 3 3 00400000 c0001000 2 00000000 10000000 00 00000000 00000000 00000000 00000000 0 0 0 920
W 0 00401f05
W 1 fc48d15e
W 2 0002af16
W 3 00000ff3
R 00400005 0048d15e 0002af16 00000003 0
T 2
X 3 3 00400123 00401456 3 00400abc 00401ffc f0 12345123 00abc456 12345abc 00abcffc 3 3 2 000
W 0 00400006
X 3 1 00400000 00000000 0 00000000 00000000 00 00000000 00000000 00000000 00000000 0 0 0 100
W 0 00800006
W 1 0000445f
W 2 0000889a
W 3 00000004
T 2
W 0 00000007
X 3 1 00800010 00000000 0 00000000 00000000 00 00000000 00000000 00000000 00000000 0 0 0 100
T 1
R 00800006 0000445e 0000889a 00000004 0
W 1 0000445f
W 2 0000889b
T 2
W 0 00000007
X 3 1 00800010 00000000 3 00801020 00801024 10 00111010 00000000 00222020 00000000 1 1 0 008
W 0 01000007
W 1 0000ccdc
W 2 0001111e
W 3 00000005
T 2
X 3 1 01000100 00000000 3 01000200 01001300 30 00000000 00000000 00000000 00444300 0 2 0 082
W 3 00000003
T 1
R 00400005 0048d15e 0002af16 00000003 0
W 3 00000000
T 4
R 00400005 0048d15e 0002af16 00000003 0
W 0 00c00005
T 4
R 00c00005 0048d15e 0002af16 80000000 0
W 0 02000007
W 1 0001555e
W 2 0001999e
T 3
T 4
R 02000007 0001555e 0001999e 00000000 1
X 3 3 02000040 02001080 0 00000000 00000000 00 00555040 00666080 00000000 00000000 3 0 0 000
